//--- project.f
source/cam_line_pkg.sv
source/line_buffer.sv
source/line_swap_buffer.sv
source/line_readout.sv
source/dual_cam_line_top.sv
tb/dual_cam_line_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the dual camera line grabber testbench with Verilator and runs it.
# The exit status is the simulator's, so a $fatal in the testbench fails this script.

set -e

cd "$(dirname "$0")"

build_dir=obj_dir
sim_name=dual_cam_line_sim

verilator \
    --binary \
    --timing \
    --assert \
    -Wno-fatal \
    --top-module dual_cam_line_tb \
    --Mdir "${build_dir}" \
    -o "${sim_name}" \
    -f project.f

"./${build_dir}/${sim_name}"

//--- source/cam_line_pkg.sv
package cam_line_pkg;

    // Field widths of the column and row counters carried with every pack.
    localparam int col_w = 11;
    localparam int row_w = 11;

    // One pixel pack as delivered by a camera, one per rclk cycle.
    typedef struct packed {
        logic [7:0]       r;
        logic [7:0]       g;
        logic [7:0]       b;
        logic             valid;     // Pack carries a pixel.
        logic             sol;       // First pixel of a line.
        logic             eol;       // Last pixel of a line.
        logic             sof;       // First line of a frame.
        logic [col_w-1:0] col;
        logic [row_w-1:0] row;
    } cam_pack_t;

    // One byte of a captured line on its way out.
    typedef struct packed {
        logic [7:0]       data;
        logic [row_w-1:0] row;
        logic             cam_id;    // 0 for camera 0, 1 for camera 1.
        logic             last;      // Final byte of the line.
    } line_beat_t;

    // Sequencer states for one trigger: camera 0, a gap, then camera 1.
    typedef enum logic [2:0] {
        idle,
        trig_cam0,
        wait_cam0,
        gap,
        trig_cam1,
        wait_cam1
    } swap_state_t;

endpackage : cam_line_pkg

//--- source/dual_cam_line_top.sv
module dual_cam_line_top #(
    parameter int H_ACT   = 1280,
    parameter int V_ACT   = 720,
    parameter int CREDITS = 4
) (
    input  logic                        rclk,
    input  logic                        rstn,
    input  logic                        trig,
    input  cam_line_pkg::cam_pack_t     cam0_pack,
    input  cam_line_pkg::cam_pack_t     cam1_pack,
    input  logic                        credit_return,
    output logic                        out_valid,
    output cam_line_pkg::line_beat_t    out_beat,
    output logic [4:0]                  frame_cnt,
    output logic                        error
);

    logic                           buf0_trig;
    logic                           buf1_trig;
    logic                           buf0_busy;
    logic                           buf1_busy;
    logic                           buf0_ready;
    logic                           buf1_ready;
    logic                           buf0_rd_en;
    logic                           buf1_rd_en;
    logic [7:0]                     buf0_data;
    logic [7:0]                     buf1_data;
    logic [cam_line_pkg::row_w-1:0] buf0_row;
    logic [cam_line_pkg::row_w-1:0] buf1_row;
    logic                           buf0_err;
    logic                           buf1_err;
    logic                           sel_ready;
    logic                           sel_rd_en;
    logic [7:0]                     sel_data;
    logic [cam_line_pkg::row_w-1:0] sel_row;
    logic                           sel_cam_id;

    line_buffer #(.H_ACT(H_ACT), .V_ACT(V_ACT)) i_buf0 (
        .rclk       (rclk),
        .rstn       (rstn),
        .cam_pack   (cam0_pack),
        .trig       (buf0_trig),
        .rd_en      (buf0_rd_en),
        .busy       (buf0_busy),
        .line_ready (buf0_ready),
        .rd_data    (buf0_data),
        .rd_row     (buf0_row),
        .error      (buf0_err)
    );

    line_buffer #(.H_ACT(H_ACT), .V_ACT(V_ACT)) i_buf1 (
        .rclk       (rclk),
        .rstn       (rstn),
        .cam_pack   (cam1_pack),
        .trig       (buf1_trig),
        .rd_en      (buf1_rd_en),
        .busy       (buf1_busy),
        .line_ready (buf1_ready),
        .rd_data    (buf1_data),
        .rd_row     (buf1_row),
        .error      (buf1_err)
    );

    line_swap_buffer #(.H_ACT(H_ACT), .V_ACT(V_ACT)) i_swap (
        .rclk       (rclk),
        .rstn       (rstn),
        .trig       (trig),
        .buf0_busy  (buf0_busy),
        .buf1_busy  (buf1_busy),
        .buf0_ready (buf0_ready),
        .buf1_ready (buf1_ready),
        .buf0_data  (buf0_data),
        .buf1_data  (buf1_data),
        .buf0_row   (buf0_row),
        .buf1_row   (buf1_row),
        .buf0_err   (buf0_err),
        .buf1_err   (buf1_err),
        .sel_rd_en  (sel_rd_en),
        .buf0_trig  (buf0_trig),
        .buf1_trig  (buf1_trig),
        .buf0_rd_en (buf0_rd_en),
        .buf1_rd_en (buf1_rd_en),
        .sel_ready  (sel_ready),
        .sel_data   (sel_data),
        .sel_row    (sel_row),
        .sel_cam_id (sel_cam_id),
        .frame_cnt  (frame_cnt),
        .error      (error)
    );

    line_readout #(.H_ACT(H_ACT), .CREDITS(CREDITS)) i_readout (
        .rclk          (rclk),
        .rstn          (rstn),
        .sel_ready     (sel_ready),
        .sel_data      (sel_data),
        .sel_row       (sel_row),
        .sel_cam_id    (sel_cam_id),
        .credit_return (credit_return),
        .sel_rd_en     (sel_rd_en),
        .out_valid     (out_valid),
        .out_beat      (out_beat)
    );

endmodule : dual_cam_line_top

//--- source/line_buffer.sv
module line_buffer #(
    parameter int H_ACT = 1280,
    parameter int V_ACT = 720
) (
    input  logic                               rclk,
    input  logic                               rstn,
    input  cam_line_pkg::cam_pack_t            cam_pack,
    input  logic                               trig,
    input  logic                               rd_en,
    output logic                               busy,
    output logic                               line_ready,
    output logic [7:0]                         rd_data,
    output logic [cam_line_pkg::row_w-1:0]     rd_row,
    output logic                               error
);

    localparam int pix_w = (H_ACT > 1) ? $clog2(H_ACT) : 1;

    typedef enum logic [1:0] {
        lb_idle,
        lb_armed,
        lb_capture,
        lb_full
    } lb_state_t;

    lb_state_t                        state;
    logic [23:0]                      mem [H_ACT];    // One word per pixel, R in the top byte.
    logic [cam_line_pkg::col_w-1:0]   exp_col;
    logic [cam_line_pkg::row_w-1:0]   line_row;
    logic [pix_w-1:0]                 rd_pix;
    logic [1:0]                       rd_lane;
    logic [23:0]                      rd_word;
    logic                             take;
    logic                             bad;
    logic                             line_end;
    logic                             rd_last;

    // A pack is taken once armed and a line starts, then until the line ends.
    assign take = cam_pack.valid &&
                  ((state == lb_armed && cam_pack.sol) || state == lb_capture);

    assign bad = (cam_pack.col != exp_col) ||
                 (cam_pack.eol && cam_pack.col != cam_line_pkg::col_w'(H_ACT - 1));

    assign line_end   = cam_pack.col == cam_line_pkg::col_w'(H_ACT - 1);
    assign rd_last    = rd_en && rd_pix == pix_w'(H_ACT - 1) && rd_lane == 2'd2;
    assign busy       = state != lb_idle;
    assign line_ready = state == lb_full;
    assign rd_word    = mem[rd_pix];

    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            state   <= lb_idle;
            exp_col <= '0;
            rd_pix  <= '0;
            rd_lane <= '0;
            error   <= 1'b0;
        end else begin
            case (state)
                lb_idle: begin
                    if (trig) begin
                        state   <= lb_armed;
                        exp_col <= '0;
                    end
                end
                lb_armed, lb_capture: begin
                    if (take) begin
                        if (bad) begin
                            error   <= 1'b1;    // Sticky until reset.
                            state   <= lb_armed;
                            exp_col <= '0;
                        end else if (line_end) begin
                            state   <= lb_full;
                            rd_pix  <= '0;
                            rd_lane <= '0;
                        end else begin
                            state   <= lb_capture;
                            exp_col <= exp_col + 1'b1;
                        end
                    end
                end
                lb_full: begin
                    if (rd_en) begin
                        if (rd_lane == 2'd2) begin
                            rd_lane <= '0;
                            rd_pix  <= rd_pix + 1'b1;
                        end else begin
                            rd_lane <= rd_lane + 1'b1;
                        end
                        if (rd_last) begin
                            state  <= lb_idle;
                            rd_pix <= '0;
                        end
                    end
                end
                default: begin
                    state <= lb_idle;
                end
            endcase
        end
    end

    always_ff @(posedge rclk) begin
        if (take && !bad) begin
            mem[cam_pack.col[pix_w-1:0]] <= {cam_pack.r, cam_pack.g, cam_pack.b};
        end
        if (take && !bad && state == lb_armed) begin
            line_row <= cam_pack.row;    // Row is taken from the sol pack.
        end
    end

    always_ff @(posedge rclk) begin
        if (rd_en) begin
            case (rd_lane)
                2'd0:    rd_data <= rd_word[23:16];
                2'd1:    rd_data <= rd_word[15:8];
                default: rd_data <= rd_word[7:0];
            endcase
            rd_row <= line_row;
        end
    end

    a_geometry: assert property (@(posedge rclk)
        H_ACT <= 2**cam_line_pkg::col_w && V_ACT <= 2**cam_line_pkg::row_w)
        else $error("H_ACT or V_ACT does not fit the column or row field");

    a_rd_when_ready: assert property (@(posedge rclk) disable iff (!rstn)
        rd_en |-> line_ready)
        else $error("read strobe without a captured line");

    // A new trigger request only ever arrives while the buffer is idle.
    a_trig_idle: assert property (@(posedge rclk) disable iff (!rstn)
        $rose(trig) |-> !busy)
        else $error("trigger raised while the buffer is busy");

endmodule : line_buffer

//--- source/line_readout.sv
module line_readout #(
    parameter int H_ACT   = 1280,
    parameter int CREDITS = 4
) (
    input  logic                               rclk,
    input  logic                               rstn,
    input  logic                               sel_ready,
    input  logic [7:0]                         sel_data,
    input  logic [cam_line_pkg::row_w-1:0]     sel_row,
    input  logic                               sel_cam_id,
    input  logic                               credit_return,
    output logic                               sel_rd_en,
    output logic                               out_valid,
    output cam_line_pkg::line_beat_t           out_beat
);

    localparam int line_bytes = 3 * H_ACT;
    localparam int byte_w     = $clog2(line_bytes);
    localparam int crd_w      = $clog2(CREDITS + 1);

    logic [crd_w-1:0]  credit_cnt;
    logic [byte_w-1:0] byte_cnt;
    logic              last_q;

    // A credit is reserved on issue, so beats in flight are already paid for.
    assign sel_rd_en = sel_ready && credit_cnt != '0;

    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            credit_cnt <= crd_w'(CREDITS);
            byte_cnt   <= '0;
            out_valid  <= 1'b0;
            last_q     <= 1'b0;
        end else begin
            case ({sel_rd_en, credit_return})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
            out_valid <= sel_rd_en;
            last_q    <= sel_rd_en && byte_cnt == byte_w'(line_bytes - 1);
            if (sel_rd_en) begin
                if (byte_cnt == byte_w'(line_bytes - 1)) begin
                    byte_cnt <= '0;
                end else begin
                    byte_cnt <= byte_cnt + 1'b1;
                end
            end
        end
    end

    // Data and row arrive registered from the buffer, so the beat forms here.
    always_comb begin
        out_beat.data   = sel_data;
        out_beat.row    = sel_row;
        out_beat.cam_id = sel_cam_id;
        out_beat.last   = last_q;
    end

    a_credit_max: assert property (@(posedge rclk) disable iff (!rstn)
        credit_cnt <= crd_w'(CREDITS))
        else $error("more credits returned than were issued");

    // The beat on the output still holds its credit in reserve.
    a_beat_reserved: assert property (@(posedge rclk) disable iff (!rstn)
        out_valid |-> credit_cnt < crd_w'(CREDITS))
        else $error("beat sent without a reserved credit");

endmodule : line_readout

//--- source/line_swap_buffer.sv
module line_swap_buffer #(
    parameter int H_ACT = 1280,
    parameter int V_ACT = 720
) (
    input  logic                               rclk,
    input  logic                               rstn,
    input  logic                               trig,
    input  logic                               buf0_busy,
    input  logic                               buf1_busy,
    input  logic                               buf0_ready,
    input  logic                               buf1_ready,
    input  logic [7:0]                         buf0_data,
    input  logic [7:0]                         buf1_data,
    input  logic [cam_line_pkg::row_w-1:0]     buf0_row,
    input  logic [cam_line_pkg::row_w-1:0]     buf1_row,
    input  logic                               buf0_err,
    input  logic                               buf1_err,
    input  logic                               sel_rd_en,
    output logic                               buf0_trig,
    output logic                               buf1_trig,
    output logic                               buf0_rd_en,
    output logic                               buf1_rd_en,
    output logic                               sel_ready,
    output logic [7:0]                         sel_data,
    output logic [cam_line_pkg::row_w-1:0]     sel_row,
    output logic                               sel_cam_id,
    output logic [4:0]                         frame_cnt,
    output logic                               error
);

    localparam int gap_w = $clog2(H_ACT + 1);

    cam_line_pkg::swap_state_t state;
    logic [gap_w-1:0]          gap_cnt;
    logic                      cam_id;
    logic                      cam_id_d;    // Follows the buffer read latency.

    // Reads and ready follow cam_id, returned data follows the delayed copy.
    assign buf0_rd_en = sel_rd_en && !cam_id;
    assign buf1_rd_en = sel_rd_en && cam_id;
    assign sel_ready  = cam_id ? buf1_ready : buf0_ready;
    assign sel_data   = cam_id_d ? buf1_data : buf0_data;
    assign sel_row    = cam_id_d ? buf1_row : buf0_row;
    assign sel_cam_id = cam_id_d;
    assign error      = buf0_err | buf1_err;

    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            state     <= cam_line_pkg::idle;
            gap_cnt   <= '0;
            cam_id    <= 1'b0;
            cam_id_d  <= 1'b0;
            buf0_trig <= 1'b0;
            buf1_trig <= 1'b0;
            frame_cnt <= '0;
        end else begin
            cam_id_d <= cam_id;
            case (state)
                cam_line_pkg::idle: begin
                    cam_id  <= 1'b0;
                    gap_cnt <= '0;
                    if (trig) begin
                        frame_cnt <= frame_cnt + 1'b1;    // Wraps at 32.
                        buf0_trig <= 1'b1;
                        state     <= cam_line_pkg::trig_cam0;
                    end
                end
                cam_line_pkg::trig_cam0: begin
                    if (buf0_busy) begin
                        buf0_trig <= 1'b0;
                        state     <= cam_line_pkg::wait_cam0;
                    end
                end
                cam_line_pkg::wait_cam0: begin
                    if (!buf0_busy) begin
                        gap_cnt <= '0;
                        state   <= cam_line_pkg::gap;
                    end
                end
                cam_line_pkg::gap: begin
                    if (gap_cnt != gap_w'(H_ACT)) begin
                        gap_cnt <= gap_cnt + 1'b1;
                    end else begin
                        cam_id <= 1'b1;
                        if (!buf0_busy && !buf1_busy) begin
                            buf1_trig <= 1'b1;
                            state     <= cam_line_pkg::trig_cam1;
                        end
                    end
                end
                cam_line_pkg::trig_cam1: begin
                    if (buf1_busy) begin
                        buf1_trig <= 1'b0;
                        state     <= cam_line_pkg::wait_cam1;
                    end
                end
                cam_line_pkg::wait_cam1: begin
                    if (!buf1_busy) begin
                        state <= cam_line_pkg::idle;
                    end
                end
                default: begin
                    state <= cam_line_pkg::idle;
                end
            endcase
        end
    end

    a_rd_exclusive: assert property (@(posedge rclk) disable iff (!rstn)
        !(buf0_rd_en && buf1_rd_en))
        else $error("both buffers read in one cycle");

    a_gap_bound: assert property (@(posedge rclk) disable iff (!rstn)
        state == cam_line_pkg::gap |-> gap_cnt <= gap_w'(H_ACT))
        else $error("gap counter ran past H_ACT");

    // Returned rows come from the active picture area.
    a_row_range: assert property (@(posedge rclk) disable iff (!rstn)
        $past(buf0_rd_en || buf1_rd_en) |-> sel_row < V_ACT)
        else $error("row outside the active area");

endmodule : line_swap_buffer

//--- tb/dual_cam_line_tb.sv
module dual_cam_line_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int H_ACT      = 16;
    localparam int V_ACT      = 8;
    localparam int CREDITS    = 4;
    localparam int line_bytes = 3 * H_ACT;
    localparam int blank_max  = 4;
    localparam int drop_col   = 5;    // Pixel left out of a faulty line.
    localparam int n_trig     = 5;    // Accepted triggers in the run.
    localparam int seq_cycles = 2 * V_ACT * (H_ACT + blank_max) + 2 * 3 * H_ACT * 8 + H_ACT;
    localparam int watchdog_cycles = n_trig * seq_cycles + 1000;

    logic                     rclk = 1'b0;
    logic                     rstn;
    logic                     trig;
    logic                     credit_return;
    logic                     credit_hold;
    logic                     cam_fault;      // Camera 0 drops a pixel in each new line.
    logic                     fault_on;
    cam_line_pkg::cam_pack_t  pack_q [2];
    logic                     out_valid;
    cam_line_pkg::line_beat_t out_beat;
    logic [4:0]               frame_cnt;
    logic                     error;

    // Reference state, updated on the same edges as the DUT.
    int                             beat_idx;
    logic                           line_cam;
    logic [cam_line_pkg::row_w-1:0] line_row;
    logic                           seq_busy;
    logic [4:0]                     frame_exp;
    logic                           trig_seen;
    int                             outstanding;

    dual_cam_line_top #(.H_ACT(H_ACT), .V_ACT(V_ACT), .CREDITS(CREDITS)) i_dut (
        .rclk          (rclk),
        .rstn          (rstn),
        .trig          (trig),
        .cam0_pack     (pack_q[0]),
        .cam1_pack     (pack_q[1]),
        .credit_return (credit_return),
        .out_valid     (out_valid),
        .out_beat      (out_beat),
        .frame_cnt     (frame_cnt),
        .error         (error)
    );

    always #5 rclk = ~rclk;

    function automatic logic [7:0] pixel_byte(input int c, input int row, input int col,
                                              input int k);
        return 8'((64 * c + row + 3 * col + k) % 256);
    endfunction

    function automatic logic [7:0] beat_byte(input logic cam,
                                             input logic [cam_line_pkg::row_w-1:0] row,
                                             input int idx);
        return pixel_byte(int'(cam), int'(row), idx / 3, idx % 3);
    endfunction

    function automatic cam_line_pkg::cam_pack_t make_pack(input int c, input int row,
                                                          input int col);
        cam_line_pkg::cam_pack_t p;
        p       = '0;
        p.r     = pixel_byte(c, row, col, 0);
        p.g     = pixel_byte(c, row, col, 1);
        p.b     = pixel_byte(c, row, col, 2);
        p.valid = 1'b1;
        p.sol   = col == 0;
        p.eol   = col == H_ACT - 1;
        p.sof   = row == 0 && col == 0;
        p.col   = cam_line_pkg::col_w'(col);
        p.row   = cam_line_pkg::row_w'(row);
        return p;
    endfunction

    task automatic report_mismatch(input string test, input int expected, input int actual);
        $display("Regression failed");
        $display("[FAIL] %s: expected 0x%0h, actual 0x%0h", test, expected, actual);
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_problem(input string what);
        $display("Regression failed");
        $display("%s", what);
        $fatal(1, "stopped at the first error");
    endtask

    always @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            beat_idx    <= 0;
            line_cam    <= 1'b0;
            line_row    <= '0;
            seq_busy    <= 1'b0;
            frame_exp   <= '0;
            trig_seen   <= 1'b0;
            outstanding <= 0;
        end else begin
            if (trig) begin
                trig_seen <= 1'b1;
            end
            if (trig && !seq_busy) begin
                frame_exp <= frame_exp + 1'b1;    // Only a trigger from idle counts.
                seq_busy  <= 1'b1;
            end
            if (out_valid) begin
                if (beat_idx == 0) begin
                    line_row <= out_beat.row;
                end
                if (beat_idx == line_bytes - 1) begin
                    beat_idx <= 0;
                    line_cam <= !line_cam;
                    if (line_cam) begin
                        seq_busy <= 1'b0;    // Camera 1 line done ends the sequence.
                    end
                end else begin
                    beat_idx <= beat_idx + 1;
                end
            end
            outstanding <= outstanding + (out_valid ? 1 : 0) - (credit_return ? 1 : 0);
        end
    end

    // Camera models, one pack per cycle with random blanking between lines.
    initial begin
        int   cam_row [2];
        int   cam_col [2];
        int   cam_blank [2];
        logic cam_bad [2];
        logic fault_now;
        for (int c = 0; c < 2; c++) begin
            cam_row[c]   = 0;
            cam_col[c]   = 0;
            cam_blank[c] = 1 + c;
            cam_bad[c]   = 1'b0;
            pack_q[c]    = '0;
        end
        forever begin
            @(posedge rclk);
            fault_now = cam_fault;
            #1;
            for (int c = 0; c < 2; c++) begin
                if (cam_blank[c] > 0) begin
                    pack_q[c]    = '0;
                    cam_blank[c] = cam_blank[c] - 1;
                end else begin
                    if (cam_col[c] == 0) begin
                        cam_bad[c] = (c == 0) && fault_now;
                    end
                    pack_q[c] = make_pack(c, cam_row[c], cam_col[c]);
                    if (cam_bad[c] && cam_col[c] == drop_col) begin
                        pack_q[c].valid = 1'b0;
                    end
                    if (cam_col[c] == H_ACT - 1) begin
                        cam_col[c]   = 0;
                        cam_row[c]   = (cam_row[c] + 1) % V_ACT;
                        cam_blank[c] = 1 + int'($urandom % blank_max);
                    end else begin
                        cam_col[c] = cam_col[c] + 1;
                    end
                end
            end
        end
    end

    // Credit sink. Each beat is paid back after 0 to 6 cycles unless held.
    initial begin
        int   due_q [$];
        int   sink_cycle;
        logic hold_now;
        sink_cycle    = 0;
        credit_return = 1'b0;
        forever begin
            @(posedge rclk);
            hold_now = credit_hold;
            #1;
            if (out_valid) begin
                due_q.push_back(sink_cycle + int'($urandom % 7));
            end
            if (!hold_now && due_q.size() > 0 && due_q[0] <= sink_cycle) begin
                credit_return = 1'b1;
                void'(due_q.pop_front());
            end else begin
                credit_return = 1'b0;
            end
            sink_cycle = sink_cycle + 1;
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge rclk);
        $display("Regression failed");
        $display("Timeout: the run did not finish within %0d cycles", watchdog_cycles);
        $fatal(1, "watchdog expired");
    end

    task automatic next_cycle();
        @(posedge rclk);
        #1;
    endtask

    task automatic fire_trigger();
        trig = 1'b1;
        next_cycle();
        trig = 1'b0;
    endtask

    task automatic wait_sequence_end();
        while (seq_busy) begin
            next_cycle();
        end
        repeat (5) next_cycle();
    endtask

    task automatic wait_for_error();
        int n;
        n = 0;
        while (!error && n < 300) begin
            next_cycle();
            n = n + 1;
        end
        if (!error) begin
            report_problem("Error flag did not rise after camera 0 dropped a pixel");
        end
    endtask

    initial begin
        void'($urandom(32'hd81e_409f));
        rstn        = 1'b0;
        trig        = 1'b0;
        credit_hold = 1'b0;
        cam_fault   = 1'b0;
        fault_on    = 1'b0;
        repeat (10) @(posedge rclk);
        #1;
        rstn = 1'b1;
        repeat (20) next_cycle();

        fire_trigger();
        wait_sequence_end();

        fire_trigger();    // A second pulse lands while camera 0 is read out.
        while (!(line_cam == 1'b0 && beat_idx >= 5)) begin
            next_cycle();
        end
        fire_trigger();
        wait_sequence_end();

        fire_trigger();
        while (beat_idx < 10) begin
            next_cycle();
        end
        credit_hold = 1'b1;
        repeat (200) next_cycle();
        credit_hold = 1'b0;
        wait_sequence_end();

        cam_fault = 1'b1;
        fault_on  = 1'b1;
        fire_trigger();
        wait_for_error();
        cam_fault = 1'b0;
        wait_sequence_end();

        fire_trigger();
        wait_sequence_end();

        $display("Regression passed");
        $finish;
    end

    a_idle_quiet: assert property (@(posedge rclk) disable iff (!rstn)
        !trig_seen |-> !out_valid && !error && frame_cnt == 5'd0)
        else report_mismatch("idle_after_reset", 0, int'({out_valid, error, frame_cnt}));

    a_frame_count: assert property (@(posedge rclk) disable iff (!rstn)
        frame_cnt == frame_exp)
        else report_mismatch("frame_count", int'(frame_exp), int'(frame_cnt));

    a_beat_in_seq: assert property (@(posedge rclk) disable iff (!rstn)
        out_valid |-> seq_busy)
        else report_problem("A beat was sent outside a triggered sequence");

    a_beat_cam: assert property (@(posedge rclk) disable iff (!rstn)
        out_valid |-> out_beat.cam_id == line_cam)
        else report_mismatch("beat_cam_id", int'(line_cam), int'(out_beat.cam_id));

    a_beat_last: assert property (@(posedge rclk) disable iff (!rstn)
        out_valid |-> out_beat.last == (beat_idx == line_bytes - 1))
        else report_mismatch("beat_last", int'(beat_idx == line_bytes - 1),
                             int'(out_beat.last));

    a_beat_data: assert property (@(posedge rclk) disable iff (!rstn)
        out_valid |-> out_beat.data == beat_byte(out_beat.cam_id, out_beat.row, beat_idx))
        else report_mismatch("beat_data", int'(beat_byte(out_beat.cam_id, out_beat.row,
                             beat_idx)), int'(out_beat.data));

    a_row_const: assert property (@(posedge rclk) disable iff (!rstn)
        out_valid && beat_idx != 0 |-> out_beat.row == line_row)
        else report_mismatch("beat_row", int'(line_row), int'(out_beat.row));

    a_row_range: assert property (@(posedge rclk) disable iff (!rstn)
        out_valid |-> int'(out_beat.row) < V_ACT)
        else report_mismatch("row_range", V_ACT - 1, int'(out_beat.row));

    a_outstanding: assert property (@(posedge rclk) disable iff (!rstn)
        outstanding <= CREDITS)
        else report_mismatch("outstanding_beats", CREDITS, outstanding);

    // With every credit held by the sink the stream has to stall.
    a_hold_quiet: assert property (@(posedge rclk) disable iff (!rstn)
        credit_hold && outstanding == CREDITS |-> !out_valid)
        else report_mismatch("credit_hold_valid", 0, int'(out_valid));

    a_error_clean: assert property (@(posedge rclk) disable iff (!rstn)
        !fault_on |-> !error)
        else report_mismatch("error_clean", 0, int'(error));

    a_error_sticky: assert property (@(posedge rclk) disable iff (!rstn)
        $past(error) |-> error)
        else report_mismatch("error_sticky", 1, int'(error));

endmodule : dual_cam_line_tb
